//--- sb_pkg.sv
// ==========================================================
// Settings bus package: widths, FIFO depth, request struct
// and the state types of both controllers
// ==========================================================
package sb_pkg;

  // Settings bus widths
  localparam int SR_AWIDTH = 8;   // Register address
  localparam int SR_DWIDTH = 32;  // Register data
  localparam int RB_AWIDTH = 8;   // Readback address
  localparam int RB_DWIDTH = 64;  // Readback word

  // Timebase
  localparam int TIME_W = 64;

  // Honor has_time on incoming commands
  localparam bit TIMED_CMDS_EN = 1'b1;

  // Crossing FIFO address bits, depth is 2**FIFO_AW
  localparam int FIFO_AW = 2;

  // One settings transaction as carried across the bridge
  typedef struct packed {
    logic [SR_AWIDTH-1:0] addr;      // Target register
    logic [SR_DWIDTH-1:0] data;      // Write value
    logic                 has_time;  // Hold until cmd_time
    logic [TIME_W-1:0]    cmd_time;  // Release time
    logic [RB_AWIDTH-1:0] rb_addr;   // Register to read back
  } set_req_t;

  // sb side request tracking
  typedef enum logic [1:0] {
    IN_IDLE    = 2'd0,  // Ready for a strobe
    IN_PENDING = 2'd1,  // Request in flight
    IN_RB_DONE = 2'd2   // Readback presented this cycle
  } in_state_t;

  // tb side release sequence
  typedef enum logic [2:0] {
    OUT_IDLE        = 3'd0,  // Waiting for a releasable command
    OUT_ISSUED      = 3'd1,  // Downstream strobe high
    OUT_SET_PENDING = 3'd2,  // Register block still busy
    OUT_RB_PENDING  = 3'd3,  // Waiting on readback strobe
    OUT_RB_DONE     = 3'd4   // Pop request, push readback
  } out_state_t;

endpackage

//--- cdc_fifo.sv
`timescale 1ns/1ps
// ==========================================================
// Dual-clock FIFO, gray-coded pointers with two-flop
// synchronizers, depth 2**FIFO_AW
// ==========================================================
module cdc_fifo #(
  parameter int WIDTH = 8
) (
  // Write side
  input  logic             i_wclk,
  input  logic             i_wrst,
  input  logic             i_wr,
  input  logic [WIDTH-1:0] i_wdata,
  output logic             o_full,
  // Read side
  input  logic             i_rclk,
  input  logic             i_rrst,
  input  logic             i_rd,
  output logic [WIDTH-1:0] o_rdata,
  output logic             o_valid
);

  // Storage, written in wclk, read asynchronously from rclk
  logic [WIDTH-1:0] mem [0:(1 << sb_pkg::FIFO_AW)-1];

  // Pointers carry one extra bit for wrap
  logic [sb_pkg::FIFO_AW:0] wbin, wbin_next, wgray;
  logic [sb_pkg::FIFO_AW:0] rbin, rbin_next, rgray;
  logic [sb_pkg::FIFO_AW:0] rgray_w1, rgray_w2;  // Read ptr into wclk
  logic [sb_pkg::FIFO_AW:0] wgray_r1, wgray_r2;  // Write ptr into rclk
  logic                     wr_ok, rd_ok;

  function automatic logic [sb_pkg::FIFO_AW:0] bin2gray(input logic [sb_pkg::FIFO_AW:0] b);
    return b ^ (b >> 1);
  endfunction

  // Write domain
  assign wr_ok     = i_wr && !o_full;  // Writes while full are dropped
  assign wbin_next = wbin + 1'b1;

  // Full when the top two gray bits differ and the rest match
  assign o_full = (wgray == {~rgray_w2[sb_pkg::FIFO_AW:sb_pkg::FIFO_AW-1],
                             rgray_w2[sb_pkg::FIFO_AW-2:0]});

  always_ff @(posedge i_wclk) begin
    if (i_wrst) begin
      wbin     <= '0;
      wgray    <= '0;
      rgray_w1 <= '0;
      rgray_w2 <= '0;
    end else begin
      rgray_w1 <= rgray;     // First sync stage
      rgray_w2 <= rgray_w1;
      if (wr_ok) begin
        wbin  <= wbin_next;
        wgray <= bin2gray(wbin_next);
      end
    end
  end

  always_ff @(posedge i_wclk) begin
    if (wr_ok) begin
      mem[wbin[sb_pkg::FIFO_AW-1:0]] <= i_wdata;
    end
  end

  // Read domain
  assign o_valid   = (rgray != wgray_r2);  // Not empty
  assign rd_ok     = i_rd && o_valid;
  assign rbin_next = rbin + 1'b1;
  assign o_rdata   = mem[rbin[sb_pkg::FIFO_AW-1:0]];  // Head word, stable once valid

  always_ff @(posedge i_rclk) begin
    if (i_rrst) begin
      rbin     <= '0;
      rgray    <= '0;
      wgray_r1 <= '0;
      wgray_r2 <= '0;
    end else begin
      wgray_r1 <= wgray;
      wgray_r2 <= wgray_r1;
      if (rd_ok) begin
        rbin  <= rbin_next;
        rgray <= bin2gray(rbin_next);
      end
    end
  end

  // Writer must respect o_full, reader must respect o_valid
  a_no_wr_full: assert property (@(posedge i_wclk) disable iff (i_wrst)
    !(i_wr && o_full))
    else $error("cdc_fifo: write while full");

  a_no_rd_empty: assert property (@(posedge i_rclk) disable iff (i_rrst)
    !(i_rd && !o_valid))
    else $error("cdc_fifo: read while empty");

endmodule

//--- set_request_ctrl.sv
`timescale 1ns/1ps
// ==========================================================
// sb side request controller, one transaction in flight
// ==========================================================
module set_request_ctrl (
  input  logic                         sb_clk,
  input  logic                         sb_rst,
  // Master side
  input  logic                         i_set_stb,
  input  sb_pkg::set_req_t             i_set_req,
  output logic                         o_set_pending,
  output logic                         o_rb_stb,
  output logic [sb_pkg::RB_DWIDTH-1:0] o_rb_data,
  // Request FIFO write port
  output logic                         o_wr,
  output sb_pkg::set_req_t             o_wdata,
  // Readback FIFO read port
  input  logic                         i_rb_valid,
  input  logic [sb_pkg::RB_DWIDTH-1:0] i_rb_data,
  output logic                         o_rb_rd
);

  sb_pkg::in_state_t state;

  always_ff @(posedge sb_clk) begin
    if (sb_rst) begin
      state <= sb_pkg::IN_IDLE;
    end else begin
      case (state)
        sb_pkg::IN_IDLE:    if (i_set_stb) state <= sb_pkg::IN_PENDING;
        sb_pkg::IN_PENDING: if (i_rb_valid) state <= sb_pkg::IN_RB_DONE;
        sb_pkg::IN_RB_DONE: state <= sb_pkg::IN_IDLE;  // Single-cycle strobe
        default:            state <= sb_pkg::IN_IDLE;
      endcase
    end
  end

  // Push in the same cycle as the accepted strobe
  assign o_wr    = i_set_stb && (state == sb_pkg::IN_IDLE);
  assign o_wdata = i_set_req;

  assign o_set_pending = (state == sb_pkg::IN_PENDING);
  assign o_rb_stb      = (state == sb_pkg::IN_RB_DONE);
  assign o_rb_rd       = o_rb_stb;   // Pop as the word is presented
  assign o_rb_data     = i_rb_data;  // FIFO head, held until the pop

  // Master must wait for o_rb_stb before the next strobe
  a_stb_busy: assert property (@(posedge sb_clk) disable iff (sb_rst)
    i_set_stb |-> state == sb_pkg::IN_IDLE)
    else $error("set_request_ctrl: strobe dropped while busy");

  // Readback only ever answers an outstanding request
  a_rb_unsolicited: assert property (@(posedge sb_clk) disable iff (sb_rst)
    i_rb_valid |-> state != sb_pkg::IN_IDLE)
    else $error("set_request_ctrl: readback with no request");

endmodule

//--- timed_release_ctrl.sv
`timescale 1ns/1ps
// ==========================================================
// tb side release controller, holds timed commands until
// the timebase reaches them and collects the readback
// ==========================================================
module timed_release_ctrl (
  input  logic                         tb_clk,
  input  logic                         tb_rst,
  input  logic [sb_pkg::TIME_W-1:0]    i_vita_time,
  // Request FIFO read port
  input  logic                         i_req_valid,
  input  sb_pkg::set_req_t             i_req,
  output logic                         o_req_rd,
  // Register block side
  output logic                         o_m_set_stb,
  output sb_pkg::set_req_t             o_m_set_req,
  input  logic                         i_m_set_pending,
  input  logic                         i_m_rb_stb,
  input  logic [sb_pkg::RB_DWIDTH-1:0] i_m_rb_data,
  // Readback FIFO write port
  output logic                         o_rb_wr,
  output logic [sb_pkg::RB_DWIDTH-1:0] o_rb_wdata
);

  sb_pkg::out_state_t          state;
  logic [sb_pkg::TIME_W-1:0]   time_ahead;  // Timebase one tick on
  logic                        now_r;       // Time reached, registered
  logic                        late_r;      // Time passed, registered
  logic                        go;          // Head command may be released
  logic [sb_pkg::RB_DWIDTH-1:0] rb_cache;

  // Registered compare, looking one tick ahead so the flags
  // line up with the current time of a counting timebase
  assign time_ahead = i_vita_time + 1'b1;

  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      now_r  <= 1'b0;
      late_r <= 1'b0;
    end else begin
      now_r  <= (time_ahead == i_req.cmd_time);
      late_r <= (time_ahead > i_req.cmd_time);
    end
  end

  // Untimed commands pass straight through
  assign go = (sb_pkg::TIMED_CMDS_EN && i_req.has_time) ? (now_r | late_r) : 1'b1;

  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      state <= sb_pkg::OUT_IDLE;
    end else begin
      case (state)
        sb_pkg::OUT_IDLE: begin
          if (i_req_valid && go) state <= sb_pkg::OUT_ISSUED;
        end
        sb_pkg::OUT_ISSUED: begin
          state <= sb_pkg::OUT_SET_PENDING;  // Strobe lasts one cycle
        end
        sb_pkg::OUT_SET_PENDING: begin
          if (!i_m_set_pending) begin
            // Readback may come with pending dropping
            state <= i_m_rb_stb ? sb_pkg::OUT_RB_DONE : sb_pkg::OUT_RB_PENDING;
          end
        end
        sb_pkg::OUT_RB_PENDING: begin
          if (i_m_rb_stb) state <= sb_pkg::OUT_RB_DONE;
        end
        sb_pkg::OUT_RB_DONE: begin
          state <= sb_pkg::OUT_IDLE;
        end
        default: begin
          state <= sb_pkg::OUT_IDLE;
        end
      endcase
    end
  end

  // Catch the readback word while waiting for it
  always_ff @(posedge tb_clk) begin
    if (i_m_rb_stb && (state == sb_pkg::OUT_SET_PENDING ||
                       state == sb_pkg::OUT_RB_PENDING)) begin
      rb_cache <= i_m_rb_data;
    end
  end

  assign o_m_set_stb = (state == sb_pkg::OUT_ISSUED);
  assign o_m_set_req = i_req;                           // Head stays put until popped
  assign o_req_rd    = (state == sb_pkg::OUT_RB_DONE);  // Retire request
  assign o_rb_wr     = (state == sb_pkg::OUT_RB_DONE);  // and return readback together
  assign o_rb_wdata  = rb_cache;

  a_stb_pulse: assert property (@(posedge tb_clk) disable iff (tb_rst)
    o_m_set_stb |=> !o_m_set_stb)
    else $error("timed_release_ctrl: strobe longer than one cycle");

  a_stb_valid: assert property (@(posedge tb_clk) disable iff (tb_rst)
    o_m_set_stb |-> i_req_valid)
    else $error("timed_release_ctrl: strobe without request");

endmodule

//--- settings_bus_timed_2clk.sv
`timescale 1ns/1ps
// ==========================================================
// Timed settings bus bridge from an sb_clk master to a
// tb_clk register block
// ==========================================================
module settings_bus_timed_2clk (
  input  logic                         sb_clk,
  input  logic                         sb_rst,
  input  logic                         tb_clk,
  input  logic                         tb_rst,
  input  logic [sb_pkg::TIME_W-1:0]    i_vita_time,     // Running timebase
  // Master side in sb_clk
  input  logic                         i_set_stb,
  input  sb_pkg::set_req_t             i_set_req,
  output logic                         o_set_pending,
  output logic                         o_rb_stb,
  output logic [sb_pkg::RB_DWIDTH-1:0] o_rb_data,
  // Register block side in tb_clk
  output logic                         o_m_set_stb,
  output sb_pkg::set_req_t             o_m_set_req,
  input  logic                         i_m_set_pending,
  input  logic                         i_m_rb_stb,
  input  logic [sb_pkg::RB_DWIDTH-1:0] i_m_rb_data
);

  // Request path sb -> tb
  sb_pkg::set_req_t             req_wdata, req_rdata;
  logic                         req_wr, req_valid, req_rd;
  // Readback path tb -> sb
  logic [sb_pkg::RB_DWIDTH-1:0] rb_wdata, rb_rdata;
  logic                         rb_wr, rb_valid, rb_rd;

  set_request_ctrl u_req_ctrl (
    .sb_clk, .sb_rst,
    .i_set_stb, .i_set_req, .o_set_pending, .o_rb_stb, .o_rb_data,
    .o_wr(req_wr), .o_wdata(req_wdata),
    .i_rb_valid(rb_valid), .i_rb_data(rb_rdata), .o_rb_rd(rb_rd)
  );

  cdc_fifo #(.WIDTH($bits(sb_pkg::set_req_t))) u_req_fifo (
    .i_wclk(sb_clk), .i_wrst(sb_rst), .i_wr(req_wr), .i_wdata(req_wdata), .o_full(),
    .i_rclk(tb_clk), .i_rrst(tb_rst), .i_rd(req_rd), .o_rdata(req_rdata), .o_valid(req_valid)
  );

  timed_release_ctrl u_release_ctrl (
    .tb_clk, .tb_rst, .i_vita_time,
    .i_req_valid(req_valid), .i_req(req_rdata), .o_req_rd(req_rd),
    .o_m_set_stb, .o_m_set_req, .i_m_set_pending, .i_m_rb_stb, .i_m_rb_data,
    .o_rb_wr(rb_wr), .o_rb_wdata(rb_wdata)
  );

  // Readback word back to the sb side
  cdc_fifo #(.WIDTH(sb_pkg::RB_DWIDTH)) u_rb_fifo (
    .i_wclk(tb_clk), .i_wrst(tb_rst), .i_wr(rb_wr), .i_wdata(rb_wdata), .o_full(),
    .i_rclk(sb_clk), .i_rrst(sb_rst), .i_rd(rb_rd), .o_rdata(rb_rdata), .o_valid(rb_valid)
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps
// ==========================================================
// Testbench clocks and resets for the sb and tb domains
// ==========================================================
module tb_clk_gen (
  output logic o_sb_clk,
  output logic o_sb_rst,
  output logic o_tb_clk,
  output logic o_tb_rst
);

  initial begin
    o_sb_clk = 1'b0;
    forever #5 o_sb_clk = ~o_sb_clk;  // 10 ns
  end

  initial begin
    o_tb_clk = 1'b0;
    forever #7 o_tb_clk = ~o_tb_clk;  // 14 ns, unrelated to sb_clk
  end

  // Each reset spans 5 cycles of its own clock
  initial begin
    o_sb_rst = 1'b1;
    repeat (5) @(posedge o_sb_clk);
    o_sb_rst <= 1'b0;
  end

  initial begin
    o_tb_rst = 1'b1;
    repeat (5) @(posedge o_tb_clk);
    o_tb_rst <= 1'b0;
  end

endmodule

//--- tb_settings_bus.sv
`timescale 1ns/1ps
// ==========================================================
// Testbench for the timed settings bus bridge with a
// register block model and a counting timebase
// ==========================================================
module tb_settings_bus;

  localparam int NUM_TESTS   = 40;
  localparam int TIMEOUT_CYC = NUM_TESTS * 200;  // In sb_clk cycles
  localparam int K_UNTIMED   = 0;
  localparam int K_FUTURE    = 1;
  localparam int K_LATE      = 2;

  logic                         sb_clk, sb_rst, tb_clk, tb_rst;
  logic [sb_pkg::TIME_W-1:0]    i_vita_time;
  logic                         i_set_stb, i_m_set_pending, i_m_rb_stb;
  sb_pkg::set_req_t             i_set_req, o_m_set_req;
  logic [sb_pkg::RB_DWIDTH-1:0] i_m_rb_data, o_rb_data;
  logic                         o_set_pending, o_rb_stb, o_m_set_stb;

  sb_pkg::set_req_t             cur_req;     // Request in flight
  int                           cur_kind;
  logic [sb_pkg::TIME_W-1:0]    sent_vita;   // Timebase when it was sent
  logic [sb_pkg::RB_DWIDTH-1:0] exp_rb;
  logic                         in_flight;
  logic [31:0]                  exp_regs [0:255];  // Shadow of the register block
  logic [31:0]                  regs [0:255];      // Model storage
  logic [31:0]                  rng_state;
  int                           errors, passed, failed, rb_cnt, cycles;
  logic                         mdl_busy;
  int                           mdl_step, mdl_pend, mdl_last;

  tb_clk_gen u_clk (.o_sb_clk(sb_clk), .o_sb_rst(sb_rst), .o_tb_clk(tb_clk), .o_tb_rst(tb_rst));

  settings_bus_timed_2clk dut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_random(output logic [31:0] v);
    rng_state = lcg_next(rng_state);
    v = rng_state;
  endtask

  // Power-up register contents built from every address bit
  function automatic logic [31:0] fill_word(input int a);
    return {a[7:0], ~a[7:0], a[7:0] ^ 8'h3c, a[7:0] + 8'h5a};
  endfunction

  function automatic string kind_name(input int k);
    return (k == K_FUTURE) ? "timed future" : (k == K_LATE) ? "timed late" : "untimed";
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  // Timebase counts one tick per tb_clk
  always @(posedge tb_clk) i_vita_time <= i_vita_time + 64'd1;

  // Register block model holds pending 0..4 cycles and strobes readback 0..2 later
  always @(posedge tb_clk) begin
    logic [31:0] r;
    int          d_pend;
    int          d_rb;
    if (tb_rst) begin
      i_m_set_pending <= 1'b0;
      i_m_rb_stb      <= 1'b0;
      mdl_busy        <= 1'b0;
    end else if (o_m_set_stb) begin
      draw_random(r);
      d_pend = int'(r[31:16] % 5);
      draw_random(r);
      d_rb = int'(r[31:16] % 3);
      regs[o_m_set_req.addr] <= o_m_set_req.data;
      i_m_rb_data <= {32'h0, (o_m_set_req.rb_addr == o_m_set_req.addr) ?
                             o_m_set_req.data : regs[o_m_set_req.rb_addr]};
      i_m_set_pending <= (d_pend >= 1);
      i_m_rb_stb      <= (d_pend + d_rb == 0);  // Same cycle as pending low
      mdl_pend <= d_pend;
      mdl_last <= d_pend + d_rb + 1;
      mdl_step <= 2;
      mdl_busy <= (d_pend + d_rb > 0);
    end else if (mdl_busy) begin
      i_m_set_pending <= (mdl_step <= mdl_pend);
      i_m_rb_stb      <= (mdl_step == mdl_last);
      mdl_step        <= mdl_step + 1;
      if (mdl_step == mdl_last) mdl_busy <= 1'b0;
    end else begin
      i_m_set_pending <= 1'b0;
      i_m_rb_stb      <= 1'b0;
    end
  end

  // Downstream command contents and release time
  always @(posedge tb_clk) begin
    if (!tb_rst && o_m_set_stb) begin
      assert (o_m_set_req.addr == cur_req.addr)
        else report_mismatch("o_m_set_req.addr", o_m_set_req.addr, cur_req.addr);
      assert (o_m_set_req.data == cur_req.data)
        else report_mismatch("o_m_set_req.data", o_m_set_req.data, cur_req.data);
      assert (o_m_set_req.rb_addr == cur_req.rb_addr)
        else report_mismatch("o_m_set_req.rb_addr", o_m_set_req.rb_addr, cur_req.rb_addr);
      assert (o_m_set_req.has_time == cur_req.has_time)
        else report_mismatch("o_m_set_req.has_time", o_m_set_req.has_time, cur_req.has_time);
      assert (o_m_set_req.cmd_time == cur_req.cmd_time)
        else report_mismatch("o_m_set_req.cmd_time", o_m_set_req.cmd_time, cur_req.cmd_time);
      if (cur_kind == K_FUTURE) begin
        assert (i_vita_time == cur_req.cmd_time + 64'd1)
          else report_mismatch("i_vita_time", i_vita_time, cur_req.cmd_time + 64'd1);
      end
      if (cur_kind == K_LATE) begin
        assert (i_vita_time - sent_vita <= 64'd12)
          else report_problem("late command waited more than 12 tb_clk cycles");
      end
    end
  end

  // Readback word and strobe count
  always @(posedge sb_clk) begin
    if (!sb_rst && o_rb_stb) begin
      rb_cnt <= rb_cnt + 1;
      assert (o_rb_data == exp_rb) else report_mismatch("o_rb_data", o_rb_data, exp_rb);
    end
  end

  a_pend_rise: assert property (@(posedge sb_clk) disable iff (sb_rst)
    i_set_stb |=> o_set_pending)
    else report_problem("o_set_pending did not rise after the strobe");

  a_pend_fall: assert property (@(posedge sb_clk) disable iff (sb_rst)
    $fell(o_set_pending) |-> o_rb_stb)
    else report_problem("o_set_pending fell without o_rb_stb");

  a_rb_pulse: assert property (@(posedge sb_clk) disable iff (sb_rst)
    o_rb_stb |=> !o_rb_stb)
    else report_problem("o_rb_stb lasted more than one cycle");

  a_rb_after_pend: assert property (@(posedge sb_clk) disable iff (sb_rst)
    o_rb_stb |-> $past(o_set_pending))
    else report_problem("o_rb_stb without a pending request");

  a_quiet_idle: assert property (@(posedge sb_clk) disable iff (sb_rst)
    !in_flight |-> (!o_set_pending && !o_rb_stb))
    else report_problem("pending or readback strobe with no request sent");

  task automatic run_test(input int t);
    logic [31:0]      r;
    sb_pkg::set_req_t req;
    int               kind;
    int               err0;
    err0 = errors;
    @(negedge sb_clk);  // Timebase is stable here
    draw_random(r);
    kind = (t < 4) ? K_UNTIMED : int'(r[31:16] % 3);
    draw_random(r);
    req.addr = r[31:24];
    draw_random(r);
    req.data = r;
    draw_random(r);
    req.rb_addr  = (t < 2 || r[20]) ? req.addr : r[31:24];  // Same or other register
    req.has_time = (kind != K_UNTIMED);
    case (kind)
      K_FUTURE: req.cmd_time = i_vita_time + 64'd20 + 64'(r[15:0] % 40);
      K_LATE:   req.cmd_time = i_vita_time - 64'd1 - 64'(r[15:0] % 8);
      default:  req.cmd_time = {r, r};  // Ignored
    endcase
    exp_regs[req.addr] = req.data;
    @(posedge sb_clk);
    i_set_req <= req;
    i_set_stb <= 1'b1;
    cur_req   <= req;
    cur_kind  <= kind;
    sent_vita <= i_vita_time;
    exp_rb    <= {32'h0, exp_regs[req.rb_addr]};
    in_flight <= 1'b1;
    @(posedge sb_clk);
    i_set_stb <= 1'b0;
    @(negedge sb_clk);
    while (!o_rb_stb) @(negedge sb_clk);
    @(posedge sb_clk);
    in_flight <= 1'b0;
    if (errors == err0) passed++;
    else failed++;
    $display("test %0d %s: %s", t, kind_name(kind), (errors == err0) ? "ok" : "failed");
  endtask

  // Run limit
  always @(posedge sb_clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYC) begin
      $display("timeout: no readback after %0d sb_clk cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rng_state       = 32'hb288;
    i_vita_time     = '0;
    i_set_stb       = 1'b0;
    i_set_req       = '0;
    i_m_set_pending = 1'b0;
    i_m_rb_stb      = 1'b0;
    i_m_rb_data     = '0;
    in_flight       = 1'b0;
    cur_req         = '0;
    cur_kind        = K_UNTIMED;
    errors          = 0;
    passed          = 0;
    failed          = 0;
    rb_cnt          = 0;
    cycles          = 0;
    for (int a = 0; a < 256; a++) begin
      regs[a]     = fill_word(a);
      exp_regs[a] = fill_word(a);
    end
    @(negedge sb_clk);
    while (sb_rst || tb_rst) @(negedge sb_clk);
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    repeat (10) @(posedge sb_clk);  // Catch any stray strobe
    assert (rb_cnt == NUM_TESTS) else report_mismatch("o_rb_stb count", rb_cnt, NUM_TESTS);
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             NUM_TESTS, passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
sb_pkg.sv
cdc_fifo.sv
set_request_ctrl.sv
timed_release_ctrl.sv
settings_bus_timed_2clk.sv
tb_clk_gen.sv
tb_settings_bus.sv

//--- run.sh
#!/bin/sh
# Build the bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_settings_bus -f sources.f -o tb_sim
out=$(./obj_dir/tb_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
